//--- compile.f
rx_pkg.sv
signal_field_parser.sv
fcs_checker.sv
rx_control_fsm.sv
rx_packet_ctrl.sv
tb_rx_packet_ctrl.sv

//--- fcs_checker.sv
`timescale 1ns/1ps

module fcs_checker import rx_pkg::*; (
    input  logic  clock,
    input  logic  reset,

    input  logic  clear_i,
    input  logic  update_i,
    input  byte_t byte_i,

    output logic  match_o
);

    localparam logic [31:0] CRC_POLY = 32'h04c11db7;

    logic [31:0] crc_q;
    logic [31:0] crc_base;

    // msb-first crc over one byte, lsb of the byte goes in first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input byte_t data);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[31] ^ data[i];
            c  = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    // a byte arriving with the clear pulse starts a fresh crc
    assign crc_base = clear_i ? 32'hffffffff : crc_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            crc_q <= 32'hffffffff;
        end else if (update_i) begin
            crc_q <= crc_step(crc_base, byte_i);
        end else begin
            crc_q <= crc_base;
        end
    end

    // residue compare once the fcs bytes went through
    assign match_o = (crc_q == EXPECTED_FCS);

endmodule

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, then judge the log
rm -f sim.log
verilator --binary --timing -f compile.f --top-module tb_rx_packet_ctrl -o sim_rx \
    && ./obj_dir/sim_rx > sim.log 2>&1 \
    || echo "build or run error" >> sim.log
cat sim.log
grep -qF '*** TEST PASSED ***' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
exit 0

//--- rx_control_fsm.sv
`timescale 1ns/1ps

module rx_control_fsm import rx_pkg::*; (
    input  logic    clock,
    input  logic    reset,

    input  logic    power_trigger_i,
    input  logic    preamble_detected_i,
    input  logic    byte_strobe_i,

    // from the SIGNAL parser
    input  rate_t   sig_rate_i,
    input  len_t    sig_len_i,
    input  status_t sig_verdict_i,

    // from the fcs checker
    input  logic    fcs_match_i,

    output logic    signal_shift_o,
    output logic    fcs_clear_o,
    output logic    fcs_update_o,

    output logic    demod_is_ongoing_o,
    output logic    pkt_header_valid_o,
    output logic    pkt_header_valid_strobe_o,
    output rate_t   pkt_rate_o,
    output len_t    pkt_len_o,
    output count_t  byte_count_o,
    output logic    fcs_out_strobe_o,
    output logic    fcs_ok_o,
    output status_t status_code_o
);

    state_t     state_q;
    logic [1:0] sig_count_q;
    logic       fcs_clear_q;

    // byte routing only while the matching state is active
    assign signal_shift_o = (state_q == S_DECODE_SIGNAL) && byte_strobe_i;
    assign fcs_update_o   = (state_q == S_DECODE_DATA) && byte_strobe_i;
    assign fcs_clear_o    = fcs_clear_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q                   <= S_WAIT_POWER_TRIGGER;
            sig_count_q               <= '0;
            fcs_clear_q               <= 1'b0;
            demod_is_ongoing_o        <= 1'b0;
            pkt_header_valid_o        <= 1'b0;
            pkt_header_valid_strobe_o <= 1'b0;
            pkt_rate_o                <= '0;
            pkt_len_o                 <= '0;
            byte_count_o              <= '0;
            fcs_out_strobe_o          <= 1'b0;
            fcs_ok_o                  <= 1'b0;
            status_code_o             <= E_OK;
        end else begin
            // single cycle pulse unless set below
            fcs_clear_q <= 1'b0;

            case (state_q)
                S_WAIT_POWER_TRIGGER: begin
                    if (power_trigger_i) begin
                        state_q <= S_WAIT_PREAMBLE;
                    end
                end

                S_WAIT_PREAMBLE: begin
                    if (!power_trigger_i) begin
                        // power gone before any preamble
                        state_q <= S_WAIT_POWER_TRIGGER;
                    end else if (preamble_detected_i) begin
                        demod_is_ongoing_o <= 1'b1;
                        sig_count_q        <= '0;
                        byte_count_o       <= '0;
                        state_q            <= S_DECODE_SIGNAL;
                    end
                end

                //////////////////////////////////////////////////
                // SIGNAL field
                //////////////////////////////////////////////////

                S_DECODE_SIGNAL: begin
                    if (byte_strobe_i) begin
                        if (sig_count_q == 2'(SIGNAL_BYTES - 1)) begin
                            sig_count_q <= '0;
                            state_q     <= S_CHECK_SIGNAL;
                        end else begin
                            sig_count_q <= sig_count_q + 2'd1;
                        end
                    end
                end

                S_CHECK_SIGNAL: begin
                    pkt_header_valid_strobe_o <= 1'b1;
                    status_code_o             <= sig_verdict_i;
                    if (sig_verdict_i == E_OK) begin
                        pkt_header_valid_o <= 1'b1;
                        pkt_rate_o         <= sig_rate_i;
                        pkt_len_o          <= sig_len_i;
                        byte_count_o       <= '0;
                        fcs_clear_q        <= 1'b1;
                        state_q            <= S_DECODE_DATA;
                    end else begin
                        state_q <= S_SIGNAL_ERROR;
                    end
                end

                S_SIGNAL_ERROR: begin
                    pkt_header_valid_strobe_o <= 1'b0;
                    demod_is_ongoing_o        <= 1'b0;
                    state_q                   <= S_WAIT_POWER_TRIGGER;
                end

                //////////////////////////////////////////////////
                // payload and fcs
                //////////////////////////////////////////////////

                S_DECODE_DATA: begin
                    pkt_header_valid_o        <= 1'b0;
                    pkt_header_valid_strobe_o <= 1'b0;

                    if (byte_strobe_i) begin
                        byte_count_o <= byte_count_o + count_t'(1);
                    end

                    // checker residue already covers the last counted byte
                    if (byte_count_o >= count_t'(pkt_len_o)) begin
                        fcs_out_strobe_o <= 1'b1;
                        fcs_ok_o         <= fcs_match_i;
                        status_code_o    <= fcs_match_i ? E_OK : E_WRONG_FCS;
                        state_q          <= S_DECODE_DONE;
                    end
                end

                S_DECODE_DONE: begin
                    fcs_out_strobe_o   <= 1'b0;
                    fcs_ok_o           <= 1'b0;
                    demod_is_ongoing_o <= 1'b0;
                    state_q            <= S_WAIT_POWER_TRIGGER;
                end

                default: begin
                    state_q <= S_WAIT_POWER_TRIGGER;
                end
            endcase
        end
    end

endmodule

//--- rx_packet_ctrl.sv
`timescale 1ns/1ps

module rx_packet_ctrl import rx_pkg::*; (
    input  logic    clock,
    input  logic    reset,

    input  rssi_t   rssi_half_db_i,
    input  rssi_t   power_thres_i,
    input  logic    preamble_detected_i,
    input  byte_t   byte_i,
    input  logic    byte_strobe_i,

    output logic    demod_is_ongoing_o,
    output logic    pkt_header_valid_o,
    output logic    pkt_header_valid_strobe_o,
    output rate_t   pkt_rate_o,
    output len_t    pkt_len_o,
    output count_t  byte_count_o,
    output logic    fcs_out_strobe_o,
    output logic    fcs_ok_o,
    output status_t status_code_o
);

    logic    power_trigger;
    logic    signal_shift;
    logic    fcs_clear;
    logic    fcs_update;
    logic    fcs_match;
    rate_t   sig_rate;
    len_t    sig_len;
    status_t sig_verdict;

    // plain level compare, no hysteresis
    assign power_trigger = (rssi_half_db_i >= power_thres_i);

    signal_field_parser signal_field_parser_i (
        .clock     (clock),
        .reset     (reset),
        .byte_i    (byte_i),
        .shift_i   (signal_shift),
        .rate_o    (sig_rate),
        .len_o     (sig_len),
        .verdict_o (sig_verdict)
    );

    rx_control_fsm rx_control_fsm_i (
        .clock                     (clock),
        .reset                     (reset),
        .power_trigger_i           (power_trigger),
        .preamble_detected_i       (preamble_detected_i),
        .byte_strobe_i             (byte_strobe_i),
        .sig_rate_i                (sig_rate),
        .sig_len_i                 (sig_len),
        .sig_verdict_i             (sig_verdict),
        .fcs_match_i               (fcs_match),
        .signal_shift_o            (signal_shift),
        .fcs_clear_o               (fcs_clear),
        .fcs_update_o              (fcs_update),
        .demod_is_ongoing_o        (demod_is_ongoing_o),
        .pkt_header_valid_o        (pkt_header_valid_o),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe_o),
        .pkt_rate_o                (pkt_rate_o),
        .pkt_len_o                 (pkt_len_o),
        .byte_count_o              (byte_count_o),
        .fcs_out_strobe_o          (fcs_out_strobe_o),
        .fcs_ok_o                  (fcs_ok_o),
        .status_code_o             (status_code_o)
    );

    fcs_checker fcs_checker_i (
        .clock    (clock),
        .reset    (reset),
        .clear_i  (fcs_clear),
        .update_i (fcs_update),
        .byte_i   (byte_i),
        .match_o  (fcs_match)
    );

endmodule

//--- rx_pkg.sv
package rx_pkg;

    //////////////////////////////////////////////////
    // basic field types
    //////////////////////////////////////////////////

    // one decoded byte from the demodulator
    typedef logic [7:0] byte_t;

    // rssi and power threshold, half-dB steps
    typedef logic [10:0] rssi_t;

    // legacy rate code, bit 3 always set for valid rates
    typedef logic [3:0] rate_t;

    // legacy length in bytes, fcs included
    typedef logic [11:0] len_t;

    // data byte counter
    typedef logic [15:0] count_t;

    //////////////////////////////////////////////////
    // status and state encodings
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        E_OK               = 4'd0,
        E_PARITY_FAIL      = 4'd1,
        E_WRONG_RSVD       = 4'd2,
        E_WRONG_TAIL       = 4'd3,
        E_UNSUPPORTED_RATE = 4'd4,
        E_WRONG_FCS        = 4'd5
    } status_t;

    typedef enum logic [2:0] {
        S_WAIT_POWER_TRIGGER = 3'd0,
        S_WAIT_PREAMBLE      = 3'd1,
        S_DECODE_SIGNAL      = 3'd2,
        S_CHECK_SIGNAL       = 3'd3,
        S_SIGNAL_ERROR       = 3'd4,
        S_DECODE_DATA        = 3'd5,
        S_DECODE_DONE        = 3'd6
    } state_t;

    // the SIGNAL field is 24 bits, three bytes
    localparam int SIGNAL_BYTES = 3;

    // crc-32 residue after a frame with a good fcs
    localparam logic [31:0] EXPECTED_FCS = 32'hc704dd7b;

endpackage

//--- signal_field_parser.sv
`timescale 1ns/1ps

module signal_field_parser import rx_pkg::*; (
    input  logic    clock,
    input  logic    reset,

    input  byte_t   byte_i,
    input  logic    shift_i,

    output rate_t   rate_o,
    output len_t    len_o,
    output status_t verdict_o
);

    // SIGNAL bits, lsb byte arrives first
    logic [23:0] sig_q;

    logic       rsvd;
    logic       parity_ok;
    logic [5:0] tail;

    always_ff @(posedge clock) begin
        if (reset) begin
            sig_q <= '0;
        end else if (shift_i) begin
            // new byte enters at the top, older ones move down
            sig_q <= {byte_i, sig_q[23:8]};
        end
    end

    //////////////////////////////////////////////////
    // field unpacking
    //////////////////////////////////////////////////

    assign rate_o    = sig_q[3:0];
    assign rsvd      = sig_q[4];
    assign len_o     = sig_q[16:5];
    assign tail      = sig_q[23:18];

    // even parity over rate, rsvd, length and the parity bit itself
    assign parity_ok = ~^sig_q[17:0];

    //////////////////////////////////////////////////
    // prioritized header check
    //////////////////////////////////////////////////

    always_comb begin
        if (!parity_ok) begin
            verdict_o = E_PARITY_FAIL;
        end else if (rsvd) begin
            verdict_o = E_WRONG_RSVD;
        end else if (|tail) begin
            verdict_o = E_WRONG_TAIL;
        end else if (!rate_o[3]) begin
            verdict_o = E_UNSUPPORTED_RATE;
        end else begin
            verdict_o = E_OK;
        end
    end

endmodule

//--- tb_rx_packet_ctrl.sv
`timescale 1ns/1ps

module tb_rx_packet_ctrl import rx_pkg::*; ();

    // bytes sent over all tests: idle, good, bad fcs, five headers, power drop
    localparam int MAX_BYTES      = 6 + 43 + 43 + 5 * 3 + 3 + 43;
    localparam int NUM_TESTS      = 10;
    localparam int TIMEOUT_CYCLES = (MAX_BYTES + 40 * NUM_TESTS) * 4;
    localparam rssi_t THRESHOLD   = 11'd200;

    logic    clock;
    logic    reset;
    rssi_t   rssi_half_db;
    rssi_t   power_thres;
    logic    preamble_detected;
    byte_t   byte_data;
    logic    byte_strobe;
    logic    demod_is_ongoing;
    logic    pkt_header_valid;
    logic    pkt_header_valid_strobe;
    rate_t   pkt_rate;
    len_t    pkt_len;
    count_t  byte_count;
    logic    fcs_out_strobe;
    logic    fcs_ok;
    status_t status_code;

    int          errors;
    int          cycles;
    logic [31:0] rng_state;
    byte_t       data_bytes [0:63];

    // what the monitor saw on the latest strobes
    int      hdr_pulses;
    int      fcs_pulses;
    logic    hdr_valid_seen;
    status_t hdr_status_seen;
    logic    fcs_ok_seen;
    status_t fcs_status_seen;
    count_t  fcs_count_seen;

    rx_packet_ctrl rx_packet_ctrl_i (
        .clock                     (clock),
        .reset                     (reset),
        .rssi_half_db_i            (rssi_half_db),
        .power_thres_i             (power_thres),
        .preamble_detected_i       (preamble_detected),
        .byte_i                    (byte_data),
        .byte_strobe_i             (byte_strobe),
        .demod_is_ongoing_o        (demod_is_ongoing),
        .pkt_header_valid_o        (pkt_header_valid),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe),
        .pkt_rate_o                (pkt_rate),
        .pkt_len_o                 (pkt_len),
        .byte_count_o              (byte_count),
        .fcs_out_strobe_o          (fcs_out_strobe),
        .fcs_ok_o                  (fcs_ok),
        .status_code_o             (status_code)
    );

    always #50 clock = ~clock;

    // outputs sampled mid-cycle
    always @(negedge clock) begin
        if (!reset && pkt_header_valid_strobe) begin
            hdr_pulses      = hdr_pulses + 1;
            hdr_valid_seen  = pkt_header_valid;
            hdr_status_seen = status_code;
        end
        if (!reset && fcs_out_strobe) begin
            fcs_pulses      = fcs_pulses + 1;
            fcs_ok_seen     = fcs_ok;
            fcs_status_seen = status_code;
            fcs_count_seen  = byte_count;
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d", errors + 1);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_status(input string name, input status_t got, input status_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rate(input string name, input rate_t got, input rate_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic count_pulses(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("expected %0d %s pulse(s) but saw %0d", exp, what, got);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // reflected crc-32, poly edb88320, final inversion
    function automatic logic [31:0] ref_crc32(input int n);
        logic [31:0] c;
        c = 32'hffffffff;
        for (int i = 0; i < n; i++) begin
            c = c ^ {24'd0, data_bytes[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    // 24-bit SIGNAL word, parity even over bits 17..0 unless flipped
    function automatic logic [23:0] make_signal(input rate_t rate, input logic rsvd,
                                                input len_t len, input logic [5:0] tail,
                                                input logic flip);
        logic p;
        p = (^{len, rsvd, rate}) ^ flip;
        return {tail, p, len, rsvd, rate};
    endfunction

    // random payload, fcs appended lsb first
    task automatic build_packet(input int len);
        logic [31:0] crc;
        logic [31:0] r;
        for (int i = 0; i < len - 4; i++) begin
            r = xorshift32();
            data_bytes[i] = r[7:0];
        end
        crc = ref_crc32(len - 4);
        for (int k = 0; k < 4; k++) begin
            data_bytes[len - 4 + k] = crc[8 * k +: 8];
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // one strobed byte, then a random idle gap of 0 to 2 cycles
    task automatic send_byte(input byte_t value);
        int gap;
        byte_data   = value;
        byte_strobe = 1'b1;
        next_cycle();
        byte_strobe = 1'b0;
        gap = int'(xorshift32() % 32'd3);
        repeat (gap) next_cycle();
    endtask

    task automatic send_packet(input logic [23:0] sig, input int n_data);
        int h0;
        h0 = hdr_pulses;
        rssi_half_db = 11'd400;
        next_cycle();
        preamble_detected = 1'b1;
        next_cycle();
        preamble_detected = 1'b0;
        check_bit("demod_is_ongoing_o", demod_is_ongoing, 1'b1);
        send_byte(sig[7:0]);
        send_byte(sig[15:8]);
        send_byte(sig[23:16]);
        // data bytes only after the header has been judged
        while (hdr_pulses == h0) begin
            next_cycle();
        end
        for (int i = 0; i < n_data; i++) begin
            send_byte(data_bytes[i]);
        end
        // end of packet, the watchdog covers a stuck fsm
        while (demod_is_ongoing) begin
            next_cycle();
        end
        rssi_half_db = 11'd0;
        repeat (3) next_cycle();
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic verify_reset_state();
        check_bit("demod_is_ongoing_o", demod_is_ongoing, 1'b0);
        check_bit("pkt_header_valid_o", pkt_header_valid, 1'b0);
        check_bit("fcs_ok_o", fcs_ok, 1'b0);
        check_status("status_code_o", status_code, E_OK);
        check_rate("pkt_rate_o", pkt_rate, 4'd0);
        check_len("pkt_len_o", pkt_len, 12'd0);
        check_count("byte_count_o", byte_count, 16'd0);
        // power below threshold, everything must be ignored
        rssi_half_db = 11'd50;
        preamble_detected = 1'b1;
        next_cycle();
        preamble_detected = 1'b0;
        for (int i = 0; i < 6; i++) begin
            send_byte(byte_t'(8'h30 + i));
        end
        repeat (10) next_cycle();
        check_bit("demod_is_ongoing_o", demod_is_ongoing, 1'b0);
        count_pulses("pkt_header_valid_strobe_o", hdr_pulses, 0);
        count_pulses("fcs_out_strobe_o", fcs_pulses, 0);
    endtask

    task automatic run_packet_check(input rate_t rate, input int len, input logic corrupt);
        int idx;
        int h0;
        int f0;
        h0 = hdr_pulses;
        f0 = fcs_pulses;
        if (corrupt) begin
            idx = int'(xorshift32() % 32'(len - 4));
            data_bytes[idx] = ~data_bytes[idx];
        end
        send_packet(make_signal(rate, 1'b0, len_t'(len), 6'd0, 1'b0), len);
        count_pulses("pkt_header_valid_strobe_o", hdr_pulses - h0, 1);
        check_bit("pkt_header_valid_o", hdr_valid_seen, 1'b1);
        check_status("status_code_o at header", hdr_status_seen, E_OK);
        check_rate("pkt_rate_o", pkt_rate, rate);
        check_len("pkt_len_o", pkt_len, len_t'(len));
        count_pulses("fcs_out_strobe_o", fcs_pulses - f0, 1);
        check_count("byte_count_o", fcs_count_seen, count_t'(len));
        check_bit("fcs_ok_o", fcs_ok_seen, !corrupt);
        check_status("status_code_o at fcs", fcs_status_seen, corrupt ? E_WRONG_FCS : E_OK);
    endtask

    task automatic bad_header_case(input logic [23:0] sig, input status_t exp);
        int h0;
        int f0;
        h0 = hdr_pulses;
        f0 = fcs_pulses;
        send_packet(sig, 0);
        count_pulses("pkt_header_valid_strobe_o", hdr_pulses - h0, 1);
        check_bit("pkt_header_valid_o", hdr_valid_seen, 1'b0);
        check_status("status_code_o", hdr_status_seen, exp);
        count_pulses("fcs_out_strobe_o", fcs_pulses - f0, 0);
    endtask

    task automatic sweep_bad_headers();
        bad_header_case(make_signal(4'hb, 1'b0, 12'd20, 6'd0, 1'b1), E_PARITY_FAIL);
        bad_header_case(make_signal(4'hb, 1'b1, 12'd20, 6'd0, 1'b0), E_WRONG_RSVD);
        bad_header_case(make_signal(4'hb, 1'b0, 12'd20, 6'h15, 1'b0), E_WRONG_TAIL);
        bad_header_case(make_signal(4'h3, 1'b0, 12'd20, 6'd0, 1'b0), E_UNSUPPORTED_RATE);
        // parity outranks tail
        bad_header_case(make_signal(4'hb, 1'b0, 12'd20, 6'h3f, 1'b1), E_PARITY_FAIL);
    endtask

    task automatic power_drop_sequence();
        logic [23:0] sig;
        int          h0;
        h0 = hdr_pulses;
        sig = make_signal(4'hd, 1'b0, 12'd12, 6'd0, 1'b0);
        rssi_half_db = 11'd400;
        repeat (2) next_cycle();
        // power falls in the same cycle as a late preamble
        rssi_half_db = 11'd0;
        preamble_detected = 1'b1;
        next_cycle();
        preamble_detected = 1'b0;
        next_cycle();
        preamble_detected = 1'b1;
        next_cycle();
        preamble_detected = 1'b0;
        send_byte(sig[7:0]);
        send_byte(sig[15:8]);
        send_byte(sig[23:16]);
        repeat (4) next_cycle();
        check_bit("demod_is_ongoing_o", demod_is_ongoing, 1'b0);
        count_pulses("pkt_header_valid_strobe_o", hdr_pulses - h0, 0);
    endtask

    initial begin
        rate_t       rate;
        int          len;
        logic [31:0] r;
        clock = 1'b0;
        reset = 1'b1;
        rssi_half_db = 11'd0;
        power_thres = THRESHOLD;
        preamble_detected = 1'b0;
        byte_data = 8'd0;
        byte_strobe = 1'b0;
        errors = 0;
        cycles = 0;
        rng_state = 32'd31;
        hdr_pulses = 0;
        fcs_pulses = 0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        next_cycle();

        verify_reset_state();

        r = xorshift32();
        rate = {1'b1, r[2:0]};
        len = 8 + int'(xorshift32() % 32'd33);
        build_packet(len);
        run_packet_check(rate, len, 1'b0);
        run_packet_check(rate, len, 1'b1);

        sweep_bad_headers();

        power_drop_sequence();
        len = 8 + int'(xorshift32() % 32'd33);
        build_packet(len);
        run_packet_check(4'he, len, 1'b0);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
